/* build.f */
+incdir+dv
hw/rv_isa_pkg.sv
hw/decode_pkg.sv
hw/instr_queue.sv
hw/imm_gen.sv
hw/instr_decoder.sv
hw/issue_stage.sv
hw/rv_decode_top.sv
dv/tb_decode_top.sv

/* dv/decode_tests.svh */
// Base format field order {funct7, rs2, rs1, funct3, rd, opcode}
function automatic logic [31:0] enc(input logic [6:0] f7, input logic [4:0] rs2,
                                    input logic [4:0] rs1, input logic [2:0] f3,
                                    input logic [4:0] rd, input logic [6:0] opc);
  return {f7, rs2, rs1, f3, rd, opc};
endfunction

// Expected micro-op from the RV32I field rules
function automatic decode_pkg::uop_t ref_uop(input decode_pkg::fetch_pkt_t p);
  decode_pkg::uop_t u;
  logic [31:0]      w;
  logic [31:0]      imm_i;
  logic             shift;
  w     = p.instr;
  imm_i = {{20{w[31]}}, w[31:20]};
  shift = (w[13:12] == 2'b01);  // funct3 001 or 101
  u     = '0;
  u.pc  = p.pc;
  case (w[6:0])
    7'h33: begin
      u.alu_op = decode_pkg::alu_op_e'({w[30], w[14:12]});
      u.rd     = w[11:7];
      u.rs1    = w[19:15];
      u.rs2    = w[24:20];
      u.rd_we  = 1'b1;
    end
    7'h13: begin
      if (shift && (w[31:25] != 7'h00) && (w[31:25] != 7'h20)) begin
        u.illegal = 1'b1;
      end else begin
        u.alu_op  = decode_pkg::alu_op_e'({w[30] && (w[14:12] == 3'd5), w[14:12]});
        u.rd      = w[11:7];
        u.rs1     = w[19:15];
        u.imm     = shift ? {27'd0, w[24:20]} : imm_i;
        u.use_imm = 1'b1;
        u.rd_we   = 1'b1;
      end
    end
    7'h37, 7'h17: begin
      u.alu_op  = decode_pkg::ALU_ADD;
      u.rd      = w[11:7];
      u.imm     = {w[31:12], 12'd0};
      u.use_imm = 1'b1;
      u.use_pc  = !w[5];  // AUIPC
      u.rd_we   = 1'b1;
    end
    7'h03, 7'h23: begin
      u.alu_op    = decode_pkg::ALU_ADD;
      u.rs1       = w[19:15];
      u.use_imm   = 1'b1;
      u.lsu_valid = 1'b1;
      u.lsu_store = w[5];
      u.lsu_size  = w[14:12];
      u.imm       = w[5] ? {{20{w[31]}}, w[31:25], w[11:7]} : imm_i;
      u.rs2       = w[5] ? w[24:20] : 5'd0;
      u.rd        = w[5] ? 5'd0 : w[11:7];
      u.rd_we     = !w[5];
    end
    7'h0f: u.alu_op = decode_pkg::ALU_ADD;  // FENCE writes nothing
    default: u.illegal = 1'b1;
  endcase
  return u;
endfunction

// Random OP, OP-IMM, LUI or AUIPC
function automatic logic [31:0] rand_alu();
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [31:0] r;
  f3 = 3'($urandom());
  r  = $urandom();
  f7 = (r[0] && ((f3 == 3'd0) || (f3 == 3'd5))) ? 7'h20 : 7'h00;
  case (2'($urandom()))
    2'd0: return enc(f7, r[12:8], r[17:13], f3, r[22:18], 7'h33);
    2'd1: return {r[31:12], r[11:7], 7'h37};
    2'd2: return {r[31:12], r[11:7], 7'h17};
    default: return (f3[1:0] == 2'b01) ? enc(f7, r[12:8], r[17:13], f3, r[22:18], 7'h13)
                                       : {r[31:20], r[17:13], f3, r[22:18], 7'h13};
  endcase
endfunction

task automatic test_reset();
  int err0;
  err0 = errors;
  check_val("reset", 128'(0), 128'(uop_valid));
  check_val("reset", 128'(0), 128'(fetch_credit));
  for (int i = 0; i < DEPTH; i++) begin
    send(rand_alu());
  end
  drain_and_compare("reset");
  check_val("reset", 128'(DEPTH), 128'(credit_pulses));  // One credit per popped packet
  report_test("reset", err0);
endtask

task automatic test_alu_random();
  int err0;
  err0 = errors;
  for (int i = 0; i < 12; i++) begin
    send(rand_alu());
  end
  drain_and_compare("alu_random");
  report_test("alu_random", err0);
endtask

task automatic test_lsu_fence();
  int          err0;
  logic [31:0] r;
  logic [2:0]  ld_f3[5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
  err0 = errors;
  for (int i = 0; i < 5; i++) begin
    r = $urandom();
    send({r[31:20], r[19:15], ld_f3[i], r[11:7], 7'h03});
    if (i < 3) begin
      send(enc(r[31:25], r[24:20], r[19:15], 3'(i), r[11:7], 7'h23));
    end
  end
  send(32'h0ff0_000f);  // FENCE iorw, iorw
  drain_and_compare("lsu_fence");
  report_test("lsu_fence", err0);
endtask

task automatic test_illegal();
  int err0;
  err0 = errors;
  send(32'h0000_002b);  // Unused major opcode
  send(32'h0000_0073);  // ECALL
  send(enc(7'h01, 5'd3, 5'd1, 3'd1, 5'd2, 7'h13));
  send(enc(7'h60, 5'd3, 5'd1, 3'd5, 5'd2, 7'h13));
  drain_and_compare("illegal");
  report_test("illegal", err0);
endtask

task automatic test_backpressure();
  int err0;
  int issued0;
  int pulses0;
  err0 = errors;
  set_credit_return(1'b0);
  issued0 = issued;
  pulses0 = credit_pulses;
  for (int i = 0; i < DEPTH + CREDITS; i++) begin
    send(rand_alu());
  end
  end_burst();
  repeat (20) @(negedge clk_i);
  check_val("backpressure", 128'(CREDITS), 128'(issued - issued0));
  set_credit_return(1'b1);
  drain_and_compare("backpressure");
  check_val("backpressure", 128'(issued - issued0), 128'(credit_pulses - pulses0));
  report_test("backpressure", err0);
endtask

// Sends two instructions back to back and checks the cycle gap of their issues
task automatic run_pair(input string name, input logic [31:0] a, input logic [31:0] b,
                        input int gap);
  int base;
  base = got_cyc.size();
  send(a);
  send(b);
  drain_and_compare(name);
  check_val(name, 128'(gap), 128'(got_cyc[base+1] - got_cyc[base]));
endtask

task automatic test_dep_hold();
  int err0;
  err0 = errors;
  run_pair("dep_none", enc(7'h00, 5'd3, 5'd1, 3'd0, 5'd5, 7'h13),
           enc(7'h00, 5'd3, 5'd2, 3'd0, 5'd6, 7'h33), 1);
  run_pair("dep_rs1", enc(7'h00, 5'd3, 5'd1, 3'd0, 5'd7, 7'h13),
           enc(7'h00, 5'd2, 5'd7, 3'd0, 5'd8, 7'h33), 2);
  run_pair("dep_rs2", enc(7'h00, 5'd3, 5'd1, 3'd0, 5'd7, 7'h13),
           enc(7'h20, 5'd7, 5'd2, 3'd0, 5'd9, 7'h33), 2);
  run_pair("dep_x0", enc(7'h00, 5'd3, 5'd1, 3'd0, 5'd0, 7'h13),
           enc(7'h00, 5'd0, 5'd0, 3'd0, 5'd9, 7'h33), 1);
  // Store imm[4:0] sits in the rd field
  run_pair("dep_store", enc(7'h00, 5'd10, 5'd1, 3'd2, 5'd11, 7'h23),
           enc(7'h00, 5'd2, 5'd11, 3'd0, 5'd12, 7'h33), 1);
  report_test("dep_hold", err0);
endtask

/* dv/tb_decode_top.sv */
`timescale 1ns/10ps

module tb_decode_top;

  localparam int DEPTH     = 4;  // DUT defaults
  localparam int CREDITS   = 2;
  localparam int NUM_TESTS = 6;

  logic                   clk_i        = 1'b0;
  logic                   rstn_i       = 1'b0;
  logic                   fetch_valid  = 1'b0;
  decode_pkg::fetch_pkt_t fetch_pkt    = '0;
  logic                   uop_credit   = 1'b0;
  logic                   fetch_credit;
  logic                   uop_valid;
  decode_pkg::uop_t       uop;

  decode_pkg::uop_t exp_q[$];
  decode_pkg::uop_t got_q[$];      // Every issued micro-op in issue order
  int               got_cyc[$];    // Issue cycle of each entry in got_q
  int               got_rd        = 0;
  int               cycle         = 0;
  int               sent          = 0;
  int               issued        = 0;
  int               returned      = 0;
  int               credit_pulses = 0;
  int               checks        = 0;
  int               errors        = 0;
  int               tests         = 0;
  logic             credit_en     = 1'b1;

  rv_decode_top i_dut (
    .clk_i          (clk_i),
    .rstn_i         (rstn_i),
    .fetch_valid_i  (fetch_valid),
    .fetch_pkt_i    (fetch_pkt),
    .fetch_credit_o (fetch_credit),
    .uop_valid_o    (uop_valid),
    .uop_o          (uop),
    .uop_credit_i   (uop_credit)
  );

  always #10 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Monitor and downstream credit return
  //////////////////////////////////////////////////////////////////////

  // Sees flop outputs as held over the cycle that just ended
  always @(posedge clk_i) begin
    if (rstn_i) begin
      if (fetch_credit) begin
        credit_pulses++;
      end
      if (uop_valid) begin
        got_q.push_back(uop);
        got_cyc.push_back(cycle);
        issued++;
      end
    end
    cycle++;
  end

  always @(negedge clk_i) begin
    if (credit_en && (issued > returned)) begin
      uop_credit = 1'b1;  // One credit back per cycle
      returned++;
    end else begin
      uop_credit = 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Upstream driver and check helpers
  //////////////////////////////////////////////////////////////////////

  task automatic send(input logic [31:0] instr);
    decode_pkg::fetch_pkt_t pkt;
    @(negedge clk_i);
    while (DEPTH - sent + credit_pulses == 0) begin
      fetch_valid = 1'b0;  // Out of fetch credits
      @(negedge clk_i);
    end
    pkt.instr   = instr;
    pkt.pc      = 32'h0000_1000 + 32'(4 * sent);
    fetch_pkt   = pkt;
    fetch_valid = 1'b1;
    exp_q.push_back(ref_uop(pkt));
    sent++;
  endtask

  task automatic end_burst();
    @(negedge clk_i);
    fetch_valid = 1'b0;
  endtask

  task automatic set_credit_return(input logic en);
    @(posedge clk_i);
    credit_en = en;
  endtask

  task automatic check_val(input string name, input logic [127:0] exp,
                           input logic [127:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Waits for all expected micro-ops and credits, then compares in order
  task automatic drain_and_compare(input string name);
    end_burst();
    while (got_q.size() - got_rd < exp_q.size()) begin
      @(negedge clk_i);
    end
    while (issued != returned) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
    while (exp_q.size() > 0) begin
      check_val(name, 128'(exp_q.pop_front()), 128'(got_q[got_rd]));
      got_rd++;
    end
    check_val(name, 128'(got_rd), 128'(got_q.size()));  // Nothing extra issued
  endtask

  task automatic report_test(input string name, input int err0);
    tests++;
    $display("%-14s finished, %0d mismatches", name, errors - err0);
  endtask

  `include "decode_tests.svh"

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(17));
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rstn_i = 1'b1;
    test_reset();
    test_alu_random();
    test_lsu_fence();
    test_illegal();
    test_backpressure();
    test_dep_hold();
    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    repeat (NUM_TESTS * 200) @(posedge clk_i);
    $display("Timeout: the tests did not finish within %0d cycles", NUM_TESTS * 200);
    $display("Verification failed");
    $finish;
  end

endmodule

/* hw/decode_pkg.sv */
package decode_pkg;

  //////////////////////////////////////////////////////////////////////
  // ALU operations, encoded as {instr[30], funct3}
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  //////////////////////////////////////////////////////////////////////
  // Stage payloads
  //////////////////////////////////////////////////////////////////////

  // One fetched instruction with its address
  typedef struct packed {
    logic [rv_isa_pkg::XLEN-1:0] instr;
    logic [rv_isa_pkg::XLEN-1:0] pc;
  } fetch_pkt_t;

  // Decoded instruction handed to execute
  typedef struct packed {
    alu_op_e                           alu_op;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2;
    logic [rv_isa_pkg::XLEN-1:0]       imm;        // Sign-extended
    logic                              use_imm;    // Operand b is imm
    logic                              use_pc;     // Operand a is pc
    logic                              rd_we;
    logic                              lsu_valid;
    logic                              lsu_store;  // Store when set, else load
    logic [rv_isa_pkg::FUNCT3_W-1:0]   lsu_size;   // Raw funct3 of the access
    logic [rv_isa_pkg::XLEN-1:0]       pc;
    logic                              illegal;
  } uop_t;

endpackage

/* hw/imm_gen.sv */
`timescale 1ns/10ps

module imm_gen (
  input  logic [rv_isa_pkg::XLEN-1:0] instr_i,
  input  rv_isa_pkg::opcode_e         opcode_i,
  output logic [rv_isa_pkg::XLEN-1:0] imm_o
);

  logic [rv_isa_pkg::FUNCT3_W-1:0] funct3;
  logic                            is_shift;
  logic [rv_isa_pkg::XLEN-1:0]     imm_i_type;
  logic [rv_isa_pkg::XLEN-1:0]     imm_shamt;
  logic [rv_isa_pkg::XLEN-1:0]     imm_s_type;
  logic [rv_isa_pkg::XLEN-1:0]     imm_u_type;

  assign funct3   = instr_i[14:12];
  assign is_shift = (funct3 == rv_isa_pkg::FUNCT3_SLL) ||
                    (funct3 == rv_isa_pkg::FUNCT3_SRL_SRA);

  //////////////////////////////////////////////////////////////////////
  // Immediate formats
  //////////////////////////////////////////////////////////////////////

  assign imm_i_type = {{(rv_isa_pkg::XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_shamt  = {{(rv_isa_pkg::XLEN-5){1'b0}}, instr_i[24:20]};  // Zero-extended
  assign imm_s_type = {{(rv_isa_pkg::XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u_type = {instr_i[31:12], 12'b0};

  always_comb begin
    case (opcode_i)
      rv_isa_pkg::OPC_LOAD:   imm_o = imm_i_type;
      rv_isa_pkg::OPC_OP_IMM: imm_o = is_shift ? imm_shamt : imm_i_type;
      rv_isa_pkg::OPC_STORE:  imm_o = imm_s_type;
      rv_isa_pkg::OPC_LUI,
      rv_isa_pkg::OPC_AUIPC:  imm_o = imm_u_type;
      default:                imm_o = '0;  // No immediate used
    endcase
  end

endmodule

/* hw/instr_decoder.sv */
`timescale 1ns/10ps

module instr_decoder (
  input  decode_pkg::fetch_pkt_t pkt_i,
  output decode_pkg::uop_t       uop_o
);

  logic [rv_isa_pkg::XLEN-1:0]       instr;
  rv_isa_pkg::opcode_e               opcode;
  logic [rv_isa_pkg::FUNCT3_W-1:0]   funct3;
  logic [rv_isa_pkg::FUNCT7_W-1:0]   funct7;
  logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1;
  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2;
  logic [rv_isa_pkg::XLEN-1:0]       imm;
  logic                              is_shift;
  logic                              bad_shift;

  //////////////////////////////////////////////////////////////////////
  // Instruction fields
  //////////////////////////////////////////////////////////////////////

  assign instr  = pkt_i.instr;
  assign opcode = rv_isa_pkg::opcode_e'(instr[rv_isa_pkg::OPCODE_W-1:0]);
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];

  assign is_shift  = (funct3 == rv_isa_pkg::FUNCT3_SLL) ||
                     (funct3 == rv_isa_pkg::FUNCT3_SRL_SRA);
  // Shift immediates allow only funct7 of zero or the SRA pattern
  assign bad_shift = is_shift && (funct7 != '0) && (funct7 != rv_isa_pkg::FUNCT7_ALT);

  imm_gen i_imm_gen (
    .instr_i  (instr),
    .opcode_i (opcode),
    .imm_o    (imm)
  );

  //////////////////////////////////////////////////////////////////////
  // Micro-op fill
  //////////////////////////////////////////////////////////////////////

  // Unread fields stay zero so the issue hold check sees only real sources
  always_comb begin
    uop_o    = '0;
    uop_o.pc = pkt_i.pc;

    case (opcode)
      rv_isa_pkg::OPC_OP: begin
        uop_o.alu_op = decode_pkg::alu_op_e'({instr[30], funct3});
        uop_o.rd     = rd;
        uop_o.rs1    = rs1;
        uop_o.rs2    = rs2;
        uop_o.rd_we  = 1'b1;
      end

      rv_isa_pkg::OPC_OP_IMM: begin
        if (bad_shift) begin
          uop_o.illegal = 1'b1;
        end else begin
          if (funct3 == rv_isa_pkg::FUNCT3_SRL_SRA) begin
            uop_o.alu_op = decode_pkg::alu_op_e'({instr[30], funct3});  // SRLI or SRAI
          end else begin
            uop_o.alu_op = decode_pkg::alu_op_e'({1'b0, funct3});
          end
          uop_o.rd      = rd;
          uop_o.rs1     = rs1;
          uop_o.imm     = imm;
          uop_o.use_imm = 1'b1;
          uop_o.rd_we   = 1'b1;
        end
      end

      rv_isa_pkg::OPC_LUI: begin
        uop_o.alu_op  = decode_pkg::ALU_ADD;  // x0 + imm
        uop_o.rd      = rd;
        uop_o.imm     = imm;
        uop_o.use_imm = 1'b1;
        uop_o.rd_we   = 1'b1;
      end

      rv_isa_pkg::OPC_AUIPC: begin
        uop_o.alu_op  = decode_pkg::ALU_ADD;  // pc + imm
        uop_o.rd      = rd;
        uop_o.imm     = imm;
        uop_o.use_imm = 1'b1;
        uop_o.use_pc  = 1'b1;
        uop_o.rd_we   = 1'b1;
      end

      rv_isa_pkg::OPC_LOAD,
      rv_isa_pkg::OPC_STORE: begin
        // Address is rs1 + imm for both
        uop_o.alu_op    = decode_pkg::ALU_ADD;
        uop_o.rs1       = rs1;
        uop_o.imm       = imm;
        uop_o.use_imm   = 1'b1;
        uop_o.lsu_valid = 1'b1;
        uop_o.lsu_store = instr[5];
        uop_o.lsu_size  = funct3;
        if (opcode == rv_isa_pkg::OPC_STORE) begin
          uop_o.rs2 = rs2;  // Store data
        end else begin
          uop_o.rd    = rd;
          uop_o.rd_we = 1'b1;
        end
      end

      rv_isa_pkg::OPC_MISC_MEM: begin
        uop_o.alu_op = decode_pkg::ALU_ADD;  // FENCE passes through with no writes
      end

      // Control flow, SYSTEM and unknown opcodes
      default: begin
        uop_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

/* hw/instr_queue.sv */
`timescale 1ns/10ps

module instr_queue #(
  parameter int DEPTH = 4
) (
  input  logic                   clk_i,
  input  logic                   rstn_i,
  input  logic                   push_i,
  input  decode_pkg::fetch_pkt_t push_pkt_i,
  input  logic                   pop_i,
  output logic                   head_valid_o,
  output decode_pkg::fetch_pkt_t head_pkt_o,
  output logic                   credit_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  decode_pkg::fetch_pkt_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + PTR_W'(1);
  endfunction

  // Push ignored when full and pop ignored when empty
  assign do_push = push_i && (count != CNT_W'(DEPTH));
  assign do_pop  = pop_i && (count != '0);

  assign head_valid_o = (count != '0);
  assign head_pkt_o   = mem[rd_ptr];  // Read combinationally by decode

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= push_pkt_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      credit_o <= 1'b0;  // Upstream starts with DEPTH credits
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
      credit_o <= do_pop;  // One credit back per freed slot
    end
  end

endmodule

/* hw/issue_stage.sv */
`timescale 1ns/10ps

module issue_stage #(
  parameter int OUT_CREDITS = 2
) (
  input  logic             clk_i,
  input  logic             rstn_i,
  input  logic             head_valid_i,
  input  decode_pkg::uop_t uop_i,
  output logic             pop_o,
  input  logic             uop_credit_i,
  output logic             uop_valid_o,
  output decode_pkg::uop_t uop_o
);

  localparam int CNT_W = $clog2(OUT_CREDITS + 1);

  logic [CNT_W-1:0] credit_cnt;
  logic             rs1_hit;
  logic             rs2_hit;
  logic             hold;
  logic             issue;

  //////////////////////////////////////////////////////////////////////
  // Dependency hold
  //////////////////////////////////////////////////////////////////////

  // uop_o still holds last cycle's micro-op while uop_valid_o is high
  assign rs1_hit = (uop_i.rs1 != '0) && (uop_i.rs1 == uop_o.rd);
  assign rs2_hit = (uop_i.rs2 != '0) && (uop_i.rs2 == uop_o.rd);
  assign hold    = uop_valid_o && uop_o.rd_we && (rs1_hit || rs2_hit);

  assign issue = head_valid_i && (credit_cnt != '0) && !hold;
  assign pop_o = issue;  // Head leaves the queue as it is registered

  //////////////////////////////////////////////////////////////////////
  // Downstream credits
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      credit_cnt <= CNT_W'(OUT_CREDITS);
    end else begin
      // Issue and return in one cycle cancel out
      case ({issue, uop_credit_i})
        2'b10:   credit_cnt <= credit_cnt - CNT_W'(1);
        2'b01:   credit_cnt <= credit_cnt + CNT_W'(1);
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      uop_valid_o <= 1'b0;
    end else begin
      uop_valid_o <= issue;  // One-cycle pulse per micro-op
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      uop_o <= uop_i;
    end
  end

endmodule

/* hw/rv_decode_top.sv */
`timescale 1ns/10ps

module rv_decode_top #(
  parameter int INSTR_QUEUE_DEPTH = 4,
  parameter int OUT_CREDITS       = 2
) (
  input  logic                   clk_i,
  input  logic                   rstn_i,
  input  logic                   fetch_valid_i,
  input  decode_pkg::fetch_pkt_t fetch_pkt_i,
  output logic                   fetch_credit_o,
  output logic                   uop_valid_o,
  output decode_pkg::uop_t       uop_o,
  input  logic                   uop_credit_i
);

  logic                   head_valid;
  decode_pkg::fetch_pkt_t head_pkt;
  decode_pkg::uop_t       head_uop;
  logic                   pop;

  // Fetch side, credit per popped entry
  instr_queue #(
    .DEPTH (INSTR_QUEUE_DEPTH)
  ) i_instr_queue (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .push_i       (fetch_valid_i),
    .push_pkt_i   (fetch_pkt_i),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_pkt_o   (head_pkt),
    .credit_o     (fetch_credit_o)
  );

  instr_decoder i_instr_decoder (
    .pkt_i (head_pkt),
    .uop_o (head_uop)
  );

  // Execute side
  issue_stage #(
    .OUT_CREDITS (OUT_CREDITS)
  ) i_issue_stage (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .head_valid_i (head_valid),
    .uop_i        (head_uop),
    .pop_o        (pop),
    .uop_credit_i (uop_credit_i),
    .uop_valid_o  (uop_valid_o),
    .uop_o        (uop_o)
  );

endmodule

/* hw/rv_isa_pkg.sv */
package rv_isa_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int XLEN       = 32;  // Data and address width
  localparam int REG_ADDR_W = 5;
  localparam int OPCODE_W   = 7;
  localparam int FUNCT3_W   = 3;
  localparam int FUNCT7_W   = 7;

  //////////////////////////////////////////////////////////////////////
  // Major opcodes, instr[6:0]
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [OPCODE_W-1:0] {
    OPC_LOAD     = 7'b0000011,
    OPC_MISC_MEM = 7'b0001111,  // FENCE
    OPC_OP_IMM   = 7'b0010011,
    OPC_AUIPC    = 7'b0010111,
    OPC_STORE    = 7'b0100011,
    OPC_OP       = 7'b0110011,
    OPC_LUI      = 7'b0110111,
    OPC_BRANCH   = 7'b1100011,
    OPC_JALR     = 7'b1100111,
    OPC_JAL      = 7'b1101111,
    OPC_SYSTEM   = 7'b1110011
  } opcode_e;

  //////////////////////////////////////////////////////////////////////
  // Function fields
  //////////////////////////////////////////////////////////////////////

  // Shift encodings in funct3
  localparam logic [FUNCT3_W-1:0] FUNCT3_SLL     = 3'b001;
  localparam logic [FUNCT3_W-1:0] FUNCT3_SRL_SRA = 3'b101;

  // Bit 30 set selects SUB and SRA
  localparam logic [FUNCT7_W-1:0] FUNCT7_ALT = 7'b0100000;

endpackage

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_decode_top -f build.f -o tb_decode_top

out=$(./obj_dir/tb_decode_top)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Verification passed'; then
  exit 0
fi
exit 1
